// File: verilog/joy_pkg.sv
package joy_pkg;

  typedef logic [11:0]        sample_t;   // adc axis value, 0..fffh
  typedef logic signed [2:0]  step_t;     // zone step, -3..+3
  typedef logic [11:0]        angle_t;    // wraps at 4096
  typedef logic [31:0]        pos_t;      // q16.16, wraps
  typedef logic [7:0]         drp_addr_t;

  localparam drp_addr_t chan_vrx = 8'h13; // vaux3
  localparam drp_addr_t chan_vry = 8'h1B; // vaux11

  // apb byte offsets, all read-only
  localparam logic [7:0] reg_yaw       = 8'h00;
  localparam logic [7:0] reg_pitch     = 8'h04;
  localparam logic [7:0] reg_pos_x     = 8'h08;
  localparam logic [7:0] reg_pos_y     = 8'h0C;
  localparam logic [7:0] reg_left_raw  = 8'h10;
  localparam logic [7:0] reg_right_raw = 8'h14;
  localparam logic [7:0] reg_frame_cnt = 8'h18;

  typedef struct packed {
    sample_t left_x;
    sample_t left_y;
    sample_t right_x;
    sample_t right_y;
  } stick_frame_t;

  typedef struct packed {
    logic      den;
    drp_addr_t daddr;
  } drp_req_t;

  typedef struct packed {
    logic        drdy;
    logic [15:0] do_data; // sample left aligned in [15:4]
  } drp_rsp_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;
  } apb_rsp_t;

  typedef struct packed {
    angle_t yaw;
    angle_t pitch;
    pos_t   pos_x;
    pos_t   pos_y;
  } motion_t;

  typedef enum logic [1:0] {
    S_SETTLE,
    S_REQ,
    S_WAIT
  } scan_state_e;

endpackage

// File: verilog/stick_zone_quantizer.sv
`timescale 1ns/1ps

module stick_zone_quantizer import joy_pkg::*; (
  input  sample_t sample,
  output step_t   step
);

  // centre is near 400h, the band 300h..500h is the dead zone
  always_comb begin
    if (sample < 12'h100) begin
      step = -3'sd3;
    end else if (sample < 12'h200) begin
      step = -3'sd2;
    end else if (sample < 12'h300) begin
      step = -3'sd1;
    end else if (sample > 12'h700) begin
      step = 3'sd3;
    end else if (sample > 12'h600) begin
      step = 3'sd2;
    end else if (sample > 12'h500) begin
      step = 3'sd1;
    end else begin
      step = 3'sd0; // dead zone
    end
  end

endmodule

// File: verilog/adc_channel_scan.sv
`timescale 1ns/1ps

module adc_channel_scan import joy_pkg::*; #(
  parameter int SETTLE_CYCLES = 16
) (
  input  logic         clk,
  input  logic         rst,
  input  drp_rsp_t     drp_rsp,
  output drp_req_t     drp_req,
  output logic         stick_sel,
  output stick_frame_t frame,
  output logic         frame_valid
);

  localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

  scan_state_e      state;
  logic [CNT_W-1:0] settle_cnt;
  logic [1:0]       axis_idx;     // 0 lx, 1 ly, 2 rx, 3 ry
  sample_t          held [0:2];   // first three samples of the frame in progress
  sample_t          sample;

  assign sample    = drp_rsp.do_data[15:4];
  assign stick_sel = axis_idx[1]; // moves on the edge into S_SETTLE only

  assign drp_req.den   = (state == S_REQ);
  assign drp_req.daddr = axis_idx[0] ? chan_vry : chan_vrx;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= S_SETTLE;
      settle_cnt  <= '0;
      axis_idx    <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= 1'b0;
      case (state)
        S_SETTLE: begin
          if (settle_cnt == CNT_W'(SETTLE_CYCLES - 1)) begin
            settle_cnt <= '0;
            state      <= S_REQ;
          end else begin
            settle_cnt <= settle_cnt + 1'b1; // let the analog mux settle
          end
        end
        S_REQ: begin
          state <= S_WAIT; // den is up for this single cycle
        end
        S_WAIT: begin
          if (drp_rsp.drdy) begin
            axis_idx <= axis_idx + 2'd1; // wraps back to left_x
            state    <= S_SETTLE;
            if (axis_idx == 2'd3) begin
              frame_valid <= 1'b1;
            end
          end
        end
        default: state <= S_SETTLE;
      endcase
    end
  end

  // the whole frame is published at once with the last sample
  always_ff @(posedge clk) begin
    if (state == S_WAIT && drp_rsp.drdy) begin
      if (axis_idx == 2'd3) begin
        frame <= '{left_x: held[0], left_y: held[1], right_x: held[2], right_y: sample};
      end else begin
        held[axis_idx] <= sample;
      end
    end
  end

endmodule

// File: verilog/motion_integrator.sv
`timescale 1ns/1ps

module motion_integrator import joy_pkg::*; #(
  parameter pos_t POS_STEP   = 32'h0000_0A3D,
  parameter int   ANGLE_UNIT = 16
) (
  input  logic         clk,
  input  logic         rst,
  input  stick_frame_t frame,
  input  logic         frame_valid,
  output motion_t      motion
);

  step_t  lx_step;
  step_t  ly_step;
  step_t  rx_step;
  step_t  ry_step;
  angle_t yaw_delta;
  angle_t pitch_delta;
  pos_t   x_delta;
  pos_t   y_delta;

  stick_zone_quantizer lx_quant (.sample(frame.left_x),  .step(lx_step));
  stick_zone_quantizer ly_quant (.sample(frame.left_y),  .step(ly_step));
  stick_zone_quantizer rx_quant (.sample(frame.right_x), .step(rx_step));
  stick_zone_quantizer ry_quant (.sample(frame.right_y), .step(ry_step));

  // position ignores the zone depth, only the direction counts
  function automatic pos_t pos_delta(step_t s);
    if (s > 0) begin
      return POS_STEP;
    end else if (s < 0) begin
      return -POS_STEP;
    end else begin
      return '0;
    end
  endfunction

  assign yaw_delta   = angle_t'(ANGLE_UNIT * rx_step); // signed, truncates mod 4096
  assign pitch_delta = angle_t'(ANGLE_UNIT * ry_step);
  assign x_delta     = pos_delta(lx_step);
  assign y_delta     = pos_delta(ly_step);

  always_ff @(posedge clk) begin
    if (rst) begin
      motion <= '0;
    end else if (frame_valid) begin
      motion.yaw   <= motion.yaw - yaw_delta;     // stick right turns yaw down
      motion.pitch <= motion.pitch + pitch_delta;
      motion.pos_x <= motion.pos_x - x_delta;     // x axis mounted inverted
      motion.pos_y <= motion.pos_y + y_delta;
    end
  end

endmodule

// File: verilog/joy_apb_regs.sv
`timescale 1ns/1ps

module joy_apb_regs import joy_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  apb_req_t     apb_req,
  output apb_rsp_t     apb_rsp,
  input  motion_t      motion,
  input  stick_frame_t frame,
  input  logic         frame_valid
);

  stick_frame_t last_frame;
  logic [31:0]  frame_cnt;
  logic         setup;
  logic [31:0]  rd_data;
  logic         acc_err;
  logic [31:0]  prdata_q;
  logic         slverr_q;

  assign setup = apb_req.psel && !apb_req.penable;

  always_comb begin
    rd_data = '0;
    acc_err = 1'b0;
    case (apb_req.paddr)
      reg_yaw:       rd_data = {20'h0, motion.yaw};
      reg_pitch:     rd_data = {20'h0, motion.pitch};
      reg_pos_x:     rd_data = motion.pos_x;
      reg_pos_y:     rd_data = motion.pos_y;
      reg_left_raw:  rd_data = {8'h0, last_frame.left_x, last_frame.left_y};
      reg_right_raw: rd_data = {8'h0, last_frame.right_x, last_frame.right_y};
      reg_frame_cnt: rd_data = frame_cnt;
      default:       acc_err = 1'b1; // unmapped offset
    endcase
    if (apb_req.pwrite) begin
      acc_err = 1'b1; // nothing here is writable
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_frame <= '0;
      frame_cnt  <= '0;
      slverr_q   <= 1'b0;
    end else begin
      slverr_q <= setup && acc_err; // held for the access phase only
      if (frame_valid) begin
        last_frame <= frame;
        frame_cnt  <= frame_cnt + 32'd1;
      end
    end
  end

  // sampled in setup so the access phase returns setup-time values
  always_ff @(posedge clk) begin
    if (setup) begin
      prdata_q <= rd_data;
    end
  end

  assign apb_rsp.pready  = apb_req.psel && apb_req.penable; // no wait states
  assign apb_rsp.pslverr = slverr_q;
  assign apb_rsp.prdata  = prdata_q;

endmodule

// File: verilog/joystick_ctrl_top.sv
`timescale 1ns/1ps

module joystick_ctrl_top import joy_pkg::*; #(
  parameter int   SETTLE_CYCLES = 16,
  parameter pos_t POS_STEP      = 32'h0000_0A3D, // about 0.04 in q16.16
  parameter int   ANGLE_UNIT    = 16
) (
  input  logic     clk,
  input  logic     rst,
  input  drp_rsp_t drp_rsp,
  output drp_req_t drp_req,
  output logic     stick_sel,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp
);

  stick_frame_t frame;
  logic         frame_valid; // one pulse per completed scan
  motion_t      motion;

  adc_channel_scan #(
    .SETTLE_CYCLES(SETTLE_CYCLES)
  ) scan_inst (
    .clk        (clk),
    .rst        (rst),
    .drp_rsp    (drp_rsp),
    .drp_req    (drp_req),
    .stick_sel  (stick_sel),
    .frame      (frame),
    .frame_valid(frame_valid)
  );

  motion_integrator #(
    .POS_STEP  (POS_STEP),
    .ANGLE_UNIT(ANGLE_UNIT)
  ) motion_inst (
    .clk        (clk),
    .rst        (rst),
    .frame      (frame),
    .frame_valid(frame_valid),
    .motion     (motion)
  );

  joy_apb_regs regs_inst (
    .clk        (clk),
    .rst        (rst),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .motion     (motion),
    .frame      (frame),
    .frame_valid(frame_valid)
  );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter realtime PERIOD       = 100.0,
  parameter int      RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #10 rst = 1'b0; // released off the edge like all other stimulus
  end

endmodule

// File: tb/joystick_chk.sv
`timescale 1ns/1ps

module joystick_chk import joy_pkg::*; (
  input logic     clk,
  input logic     rst,
  input drp_req_t drp_req,
  input drp_rsp_t drp_rsp,
  input apb_rsp_t apb_rsp,
  input logic     frame_valid
);

  logic      assert_fired = 1'b0; // polled by the testbench
  logic      pending;             // drp read in flight
  drp_addr_t req_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending  <= 1'b0;
      req_addr <= '0;
    end else if (drp_req.den) begin
      pending  <= 1'b1;
      req_addr <= drp_req.daddr;
    end else if (drp_rsp.drdy) begin
      pending <= 1'b0;
    end
  end

  a_one_read: assert property (@(posedge clk) disable iff (rst) pending |-> !drp_req.den)
    else begin
      assert_fired = 1'b1;
      $error("DRP read issued while another read was outstanding");
    end

  a_addr_stable: assert property (@(posedge clk) disable iff (rst)
    pending |-> drp_req.daddr == req_addr)
    else begin
      assert_fired = 1'b1;
      $error("DRP address changed before drdy");
    end

  a_valid_pulse: assert property (@(posedge clk) disable iff (rst) frame_valid |=> !frame_valid)
    else begin
      assert_fired = 1'b1;
      $error("frame_valid high for two cycles in a row");
    end

  a_err_ready: assert property (@(posedge clk) disable iff (rst)
    apb_rsp.pslverr |-> apb_rsp.pready)
    else begin
      assert_fired = 1'b1;
      $error("pslverr without pready");
    end

endmodule

bind joystick_ctrl_top joystick_chk chk_inst (
  .clk        (clk),
  .rst        (rst),
  .drp_req    (drp_req),
  .drp_rsp    (drp_rsp),
  .apb_rsp    (apb_rsp),
  .frame_valid(frame_valid)
);

// File: tb/joystick_tb.sv
`timescale 1ns/1ps

module joystick_tb import joy_pkg::*; ();

  localparam int   SETTLE     = 4;
  localparam pos_t POS_STEP   = 32'h0000_0A3D;
  localparam int   ANGLE_UNIT = 16;

  // zone edges and a few points inside each zone
  localparam sample_t zone_tab [0:13] = '{12'h050, 12'h0FF, 12'h100, 12'h1FF, 12'h200,
    12'h2FF, 12'h300, 12'h500, 12'h501, 12'h600, 12'h601, 12'h700, 12'h701, 12'hFFF};

  logic         clk;
  logic         rst;
  drp_req_t     drp_req;
  drp_rsp_t     drp_rsp;
  logic         stick_sel;
  apb_req_t     apb_req;
  apb_rsp_t     apb_rsp;
  stick_frame_t stick;        // stick positions set by the test
  stick_frame_t served;       // positions the adc model uses for the frame in progress
  int           frame_budget; // frames the adc model may still start
  logic [31:0]  rng;
  motion_t      exp_motion;
  logic [31:0]  exp_count;

  tb_clock clk_gen (.clk(clk), .rst(rst));

  joystick_ctrl_top #(
    .SETTLE_CYCLES(SETTLE),
    .POS_STEP     (POS_STEP),
    .ANGLE_UNIT   (ANGLE_UNIT)
  ) joystick_ctrl_top_inst (
    .clk      (clk),
    .rst      (rst),
    .drp_rsp  (drp_rsp),
    .drp_req  (drp_req),
    .stick_sel(stick_sel),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp)
  );

  task automatic fail_now(string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "stopped at first error");
  endtask

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int zone_step(sample_t s);
    if (s < 12'h100) return -3;
    if (s < 12'h200) return -2;
    if (s < 12'h300) return -1;
    if (s > 12'h700) return 3;
    if (s > 12'h600) return 2;
    if (s > 12'h500) return 1;
    return 0;
  endfunction

  function automatic int sgn(int v);
    return (v > 0) ? 1 : ((v < 0) ? -1 : 0);
  endfunction

  // expected motion after n identical frames
  function automatic motion_t advance(motion_t m, stick_frame_t f, int n);
    motion_t r;
    r.yaw   = m.yaw - angle_t'(n * ANGLE_UNIT * zone_step(f.right_x));
    r.pitch = m.pitch + angle_t'(n * ANGLE_UNIT * zone_step(f.right_y));
    r.pos_x = m.pos_x - POS_STEP * pos_t'(n * sgn(zone_step(f.left_x))); // inverted axis
    r.pos_y = m.pos_y + POS_STEP * pos_t'(n * sgn(zone_step(f.left_y)));
    return r;
  endfunction

  function automatic logic [31:0] pack_raw(sample_t x, sample_t y);
    return {8'h00, x, y};
  endfunction

  function automatic sample_t axis_value(stick_frame_t f, logic [1:0] idx);
    case (idx)
      2'd0:    return f.left_x;
      2'd1:    return f.left_y;
      2'd2:    return f.right_x;
      default: return f.right_y;
    endcase
  endfunction

  task automatic check_angle(string name, angle_t exp, angle_t act);
    if (act !== exp) fail_now($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_pos(string name, pos_t exp, pos_t act);
    if (act !== exp) fail_now($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_word(string name, logic [31:0] exp, logic [31:0] act);
    if (act !== exp) fail_now($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_err(string name, logic exp, logic act);
    if (act !== exp) fail_now($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic apb_access(logic [7:0] addr, logic write, output logic [31:0] data,
                            output logic err);
    int waited;
    @(posedge clk);
    #10;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: 32'h0};
    @(posedge clk);
    #10;
    apb_req.penable = 1'b1;
    waited = 0;
    @(negedge clk);
    while (apb_rsp.pready !== 1'b1) begin
      waited++;
      if (waited > 16) fail_now("APB access never got pready");
      @(negedge clk);
    end
    data = apb_rsp.prdata; // sampled mid cycle
    err  = apb_rsp.pslverr;
    @(posedge clk);
    #10;
    apb_req = '0;
  endtask

  task automatic read_reg(string name, logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_access(addr, 1'b0, data, err);
    check_err({name, " pslverr"}, 1'b0, err);
  endtask

  task automatic wait_frames(string name, logic [31:0] target);
    logic [31:0] cnt;
    int          polls;
    polls = 0;
    read_reg(name, reg_frame_cnt, cnt);
    while (cnt !== target) begin
      polls++;
      if (polls > 5000) begin
        fail_now($sformatf("%s: frame count stuck at %0d, waiting for %0d", name, cnt, target));
      end
      read_reg(name, reg_frame_cnt, cnt);
    end
  endtask

  // let n frames through the adc model and check every result register
  task automatic run_batch(string name, stick_frame_t f, int n);
    logic [31:0] data;
    stick        = f;
    exp_motion   = advance(exp_motion, f, n);
    exp_count    = exp_count + n;
    frame_budget = frame_budget + n;
    wait_frames(name, exp_count);
    read_reg(name, reg_yaw, data);
    check_angle({name, " yaw"}, exp_motion.yaw, data[11:0]);
    check_word({name, " yaw upper bits"}, 32'h0, data >> 12);
    read_reg(name, reg_pitch, data);
    check_angle({name, " pitch"}, exp_motion.pitch, data[11:0]);
    check_word({name, " pitch upper bits"}, 32'h0, data >> 12);
    read_reg(name, reg_pos_x, data);
    check_pos({name, " pos_x"}, exp_motion.pos_x, data);
    read_reg(name, reg_pos_y, data);
    check_pos({name, " pos_y"}, exp_motion.pos_y, data);
    read_reg(name, reg_left_raw, data);
    check_word({name, " left raw"}, pack_raw(f.left_x, f.left_y), data);
    read_reg(name, reg_right_raw, data);
    check_word({name, " right raw"}, pack_raw(f.right_x, f.right_y), data);
  endtask

  // adc model that starts a new frame only once the test grants one
  initial begin : adc_model
    int         waited;
    logic [1:0] idx;
    drp_rsp = '0;
    forever begin
      waited = 0;
      @(negedge clk);
      while (!drp_req.den) begin
        waited++;
        if (waited > 1000) fail_now("ADC model saw no DRP read");
        @(negedge clk);
      end
      if (drp_req.daddr !== chan_vrx && drp_req.daddr !== chan_vry) begin
        fail_now("DRP read of an unknown channel");
      end
      idx = {stick_sel, drp_req.daddr == chan_vry};
      if (idx == 2'd0) begin
        waited = 0;
        while (frame_budget == 0) begin
          waited++;
          if (waited > 200000) fail_now("ADC model was never granted another frame");
          @(negedge clk);
        end
        frame_budget--;
        served = stick;
      end
      rng = xorshift32(rng);
      repeat (1 + rng[1:0]) @(posedge clk); // 1 to 4 cycles of latency
      #10;
      drp_rsp.drdy    = 1'b1;
      drp_rsp.do_data = {axis_value(served, idx), 4'h0};
      @(posedge clk);
      #10;
      drp_rsp = '0;
    end
  end

  always @(posedge clk) begin
    if (joystick_ctrl_top_inst.chk_inst.assert_fired) fail_now("protocol assertion fired");
  end

  initial begin : test_seq
    int          waited;
    logic [31:0] data;
    logic        err;
    apb_req      = '0;
    stick        = '{12'h400, 12'h400, 12'h400, 12'h400};
    frame_budget = 0;
    rng          = 32'hc01bc54b;
    exp_motion   = '0;
    exp_count    = '0;
    waited = 0;
    @(posedge clk);
    while (rst) begin
      waited++;
      if (waited > 10) fail_now("reset never released");
      @(posedge clk);
    end

    run_batch("centred", '{12'h400, 12'h400, 12'h400, 12'h400}, 3);
    run_batch("raw", '{12'h3A5, 12'h4C2, 12'h31F, 12'h4F0}, 1); // all inside the dead zone

    for (int i = 0; i < 14; i++) begin
      run_batch($sformatf("right zone %0d", i),
                '{12'h400, 12'h400, zone_tab[i], zone_tab[13 - i]}, 3);
    end
    run_batch("angle wrap", '{12'h400, 12'h400, 12'h000, 12'hFFF}, 90); // 4320 units

    for (int i = 0; i < 14; i += 3) begin
      run_batch($sformatf("left zone %0d", i),
                '{zone_tab[i], zone_tab[13 - i], 12'h400, 12'h400}, 4);
    end

    apb_access(reg_yaw, 1'b1, data, err);
    check_err("write pslverr", 1'b1, err);
    apb_access(8'h1C, 1'b0, data, err);
    check_err("unmapped pslverr", 1'b1, err);
    apb_access(reg_pitch, 1'b0, data, err);
    check_err("mapped pslverr", 1'b0, err);

    if (joystick_ctrl_top_inst.chk_inst.assert_fired) begin
      fail_now("protocol assertion fired");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// File: compile.f
verilog/joy_pkg.sv
verilog/stick_zone_quantizer.sv
verilog/adc_channel_scan.sv
verilog/motion_integrator.sv
verilog/joy_apb_regs.sv
verilog/joystick_ctrl_top.sv
tb/tb_clock.sv
tb/joystick_chk.sv
tb/joystick_tb.sv

// File: Bender.yml
package:
  name: joystick_ctrl

sources:
  - verilog/joy_pkg.sv
  - verilog/stick_zone_quantizer.sv
  - verilog/adc_channel_scan.sv
  - verilog/motion_integrator.sv
  - verilog/joy_apb_regs.sv
  - verilog/joystick_ctrl_top.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/joystick_chk.sv
      - tb/joystick_tb.sv
